/* common/mem_stage_pkg.sv */
// Memory stage shared definitions
// Widths, one-hot access width codes and the payload structs of the stage
package mem_stage_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned XLEN       = 64; // Data path width
    localparam int unsigned VADDR      = 39; // Virtual address width
    localparam int unsigned BE_W       = XLEN / 8; // Byte lanes per word
    localparam int unsigned REG_IDX_W  = 5; // Register file index
    localparam int unsigned BYTE_OFS_W = 3; // Byte offset inside a doubleword
    localparam int unsigned WIDTH_1H_W = 4; // One-hot access width

    ////////////////////////////////////////////////////////////
    // Access width codes
    ////////////////////////////////////////////////////////////

    localparam logic [WIDTH_1H_W-1:0] MEM_WIDTH_BYTE   = 4'b0001; // 8 bit
    localparam logic [WIDTH_1H_W-1:0] MEM_WIDTH_HALF   = 4'b0010; // 16 bit
    localparam logic [WIDTH_1H_W-1:0] MEM_WIDTH_WORD   = 4'b0100; // 32 bit
    localparam logic [WIDTH_1H_W-1:0] MEM_WIDTH_DOUBLE = 4'b1000; // 64 bit

    // Lane patterns placed at the byte offset
    localparam logic [BE_W-1:0] BE_BYTE   = 8'b0000_0001; // One lane
    localparam logic [BE_W-1:0] BE_HALF   = 8'b0000_0011; // Two lanes
    localparam logic [BE_W-1:0] BE_WORD   = 8'b0000_1111; // Four lanes
    localparam logic [BE_W-1:0] BE_DOUBLE = 8'b1111_1111; // All lanes

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    // Load/store control from execute
    typedef struct packed {
        logic [WIDTH_1H_W-1:0] width_1h; // Access width
        logic                  rd;       // Load
        logic                  wr;       // Store
        logic                  sign;     // Sign extend load data
    } mem_ctrl_t;

    // OBI address phase
    typedef struct packed {
        logic [VADDR-1:0] addr;  // Doubleword aligned
        logic             we;    // Write enable
        logic [BE_W-1:0]  be;    // Byte strobes
        logic [XLEN-1:0]  wdata; // Replicated store data
    } mem_req_t;

    // Writeback payload
    typedef struct packed {
        logic [VADDR-1:0]     pc;             // Instruction address
        logic [XLEN-1:0]      rd_data;        // Result from execute
        logic [REG_IDX_W-1:0] rd_idx;         // Destination register
        logic                 rd_wr_en;       // Register write enable
        logic                 rd_wr_src_load; // Result comes from the load
    } wb_payload_t;

    // Load formatting for writeback
    typedef struct packed {
        logic [WIDTH_1H_W-1:0] width_1h;  // Access width
        logic                  sign;      // Sign extend
        logic [BYTE_OFS_W-1:0] byte_addr; // Lane of the loaded value
    } load_fmt_t;

endpackage

/* source/validity_tracker.sv */
// Validity tracker
// Kills the instruction on squash or bubble, remembering either one across a stall
`timescale 1ns/100ps

module validity_tracker (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic valid_i,  // Instruction from execute
    input  logic squash_i, // Flush level
    input  logic bubble_i, // NOP insertion level
    input  logic stall_i,  // Stage held this cycle
    output logic valid_o   // Qualified validity
);

    logic sticky_q; // Kill seen during the current stall

    ////////////////////////////////////////////////////////////
    // Sticky kill flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            sticky_q <= 1'b0;
        end else if (!stall_i) begin
            sticky_q <= 1'b0; // Stall released, instruction has moved on
        end else if (squash_i || bubble_i) begin
            sticky_q <= 1'b1; // Kill must survive until release
        end
    end

    assign valid_o = valid_i & ~squash_i & ~bubble_i & ~sticky_q;

    // Flag only exists inside a stall
    a_sticky_in_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
        sticky_q |-> $past(stall_i))
        else $error("validity_tracker: sticky flag set outside a stall");

endmodule

/* mem_stage/access_decoder.sv */
// Load/store access decoder
// Width and alignment into byte strobes, replicated store data, word address and exceptions
`timescale 1ns/100ps

module access_decoder (
    input  logic                            valid_i,
    input  logic [mem_stage_pkg::VADDR-1:0] addr_i,     // Full byte address
    input  logic [mem_stage_pkg::XLEN-1:0]  rs2_data_i, // Store data, low aligned
    input  mem_stage_pkg::mem_ctrl_t        ctrl_i,
    output mem_stage_pkg::mem_req_t         req_o,
    output logic                            rd_req_o,   // Aligned valid load
    output logic                            wr_req_o,   // Aligned valid store
    output logic                            illegal_o,
    output logic                            unalign_load_ex_o,
    output logic                            unalign_store_ex_o
);

    import mem_stage_pkg::*;

    logic [BYTE_OFS_W-1:0] byte_ofs; // Offset inside the doubleword
    logic [BE_W-1:0]       be;       // Lane strobes
    logic [XLEN-1:0]       wdata;    // Lane replicated data
    logic                  illegal;  // Alignment violation

    assign byte_ofs = addr_i[BYTE_OFS_W-1:0];

    ////////////////////////////////////////////////////////////
    // Width decode
    ////////////////////////////////////////////////////////////

    always_comb begin : width_decode
        illegal = 1'b0;
        wdata   = rs2_data_i;
        be      = '0;
        case (ctrl_i.width_1h)
            MEM_WIDTH_BYTE: begin
                wdata = {(XLEN/8){rs2_data_i[7:0]}}; // Byte on every lane
                be    = BE_BYTE << byte_ofs;
            end
            MEM_WIDTH_HALF: begin
                illegal = byte_ofs[0]; // Odd offset
                wdata   = {(XLEN/16){rs2_data_i[15:0]}};
                be      = illegal ? '0 : BE_HALF << byte_ofs;
            end
            MEM_WIDTH_WORD: begin
                illegal = byte_ofs[1:0] != 2'b00; // Only offsets 0 and 4
                wdata   = {(XLEN/32){rs2_data_i[31:0]}};
                be      = illegal ? '0 : BE_WORD << byte_ofs;
            end
            MEM_WIDTH_DOUBLE: begin
                illegal = byte_ofs != '0; // Offset 0 only
                be      = illegal ? '0 : BE_DOUBLE;
            end
            default: begin
                illegal = 1'b1; // Not a one-hot width code
            end
        endcase

        // No lane may be enabled on a rejected access
        assert (!illegal || be == '0)
            else $error("access_decoder: strobe %h on illegal access", be);
        // Execute never marks one access as load and store
        assert (!(ctrl_i.rd && ctrl_i.wr && valid_i && !illegal))
            else $error("access_decoder: load and store requested together");
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    assign req_o.addr  = {addr_i[VADDR-1:BYTE_OFS_W], {BYTE_OFS_W{1'b0}}}; // Doubleword address
    assign req_o.we    = ctrl_i.wr;
    assign req_o.be    = be;
    assign req_o.wdata = wdata;

    assign illegal_o = illegal;
    assign rd_req_o  = ctrl_i.rd & valid_i & ~illegal;
    assign wr_req_o  = ctrl_i.wr & valid_i & ~illegal;

    assign unalign_load_ex_o  = illegal & ctrl_i.rd & valid_i;
    assign unalign_store_ex_o = illegal & ctrl_i.wr & valid_i;

endmodule

/* obi/obi_host_driver.sv */
// OBI host driver for the data port
// Issues one request at a time, tracks the response and stalls the pipeline meanwhile
`timescale 1ns/100ps

module obi_host_driver (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      rd_i,     // Load request
    input  logic                      wr_i,     // Store request
    input  mem_stage_pkg::mem_req_t   req_i,    // Decoded address phase
    input  logic                      gnt_i,
    input  logic                      rvalid_i,
    input  logic                      stall_i,  // Pipeline stall level
    output logic                      req_o,
    output mem_stage_pkg::mem_req_t   req_fields_o,
    output logic                      stall_o   // Data port busy
);

    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,     // Free for a new request
        ST_WAIT_RSP, // Granted, waiting for rvalid
        ST_PARKED    // Done, pipeline still held elsewhere
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   new_req; // Request present from decoder

    assign new_req = rd_i | wr_i;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        req_o   = 1'b0;
        stall_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                req_o   = new_req; // Same cycle as the request
                stall_o = new_req;
                if (new_req && gnt_i) begin
                    state_d = ST_WAIT_RSP;
                end
            end
            ST_WAIT_RSP: begin
                stall_o = ~rvalid_i; // Falls in the response cycle
                if (rvalid_i) begin
                    state_d = stall_i ? ST_PARKED : ST_IDLE;
                end
            end
            ST_PARKED: begin
                if (!stall_i) begin
                    state_d = ST_IDLE; // Instruction leaves, no reissue
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address phase follows the decoder, direction from the request type
    always_comb begin
        req_fields_o    = req_i;
        req_fields_o.we = wr_i;
    end

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////

    // Upstream hold keeps the address phase stable until grant
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_o && !gnt_i |=> req_o && $stable(req_fields_o))
        else $error("obi_host_driver: request dropped or changed before grant");

    a_rvalid_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> state_q == ST_WAIT_RSP)
        else $error("obi_host_driver: rvalid without outstanding request");

endmodule

/* mem_stage/mem_stage_regs.sv */
// Memory stage output registers
// Stall-aware capture of valid, writeback payload and load format
`timescale 1ns/100ps

module mem_stage_regs (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        stall_i,   // Hold all registers
    input  logic                        valid_i,   // Tracked validity
    input  logic                        illegal_i, // Misaligned access
    input  logic                        rd_i,      // Access is a load
    input  logic                        wr_i,      // Access is a store
    input  mem_stage_pkg::wb_payload_t  wb_i,
    input  mem_stage_pkg::load_fmt_t    load_fmt_i,
    output logic                        valid_o,
    output mem_stage_pkg::wb_payload_t  wb_o,
    output mem_stage_pkg::load_fmt_t    load_fmt_o
);

    import mem_stage_pkg::*;

    logic        exception; // Access raised an alignment fault
    wb_payload_t wb_gated;  // Payload with qualified write enable

    assign exception = illegal_i & (rd_i | wr_i);

    always_comb begin
        wb_gated          = wb_i;
        wb_gated.rd_wr_en = wb_i.rd_wr_en & valid_i; // Killed instructions write nothing
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_o    <= 1'b0;
            wb_o       <= '0; // Writeback sees a clean payload
            load_fmt_o <= '0;
        end else if (!stall_i) begin
            valid_o    <= valid_i & ~exception; // Faulting access leaves as invalid
            wb_o       <= wb_gated;
            load_fmt_o <= load_fmt_i;
        end
    end

endmodule

/* mem_stage/mem_stage.sv */
// Memory stage top level
// Joins validity tracking, access decoding, the OBI data port and the output registers
`timescale 1ns/100ps

module mem_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    // Pipeline control
    input  logic                                  squash_i,
    input  logic                                  bubble_i,
    input  logic                                  stall_i,
    // From execute
    input  logic                                  valid_i,
    input  logic [mem_stage_pkg::VADDR-1:0]       pc_i,
    input  logic [mem_stage_pkg::VADDR-1:0]       addr_i,      // Full byte address
    input  logic [mem_stage_pkg::XLEN-1:0]        rs2_data_i,  // Store data
    input  logic [mem_stage_pkg::XLEN-1:0]        rd_data_i,
    input  logic [mem_stage_pkg::REG_IDX_W-1:0]   rd_idx_i,
    input  logic                                  rd_wr_en_i,
    input  logic                                  rd_wr_src_load_i,
    input  mem_stage_pkg::mem_ctrl_t              ctrl_i,
    // OBI data port
    output logic                                  dmem_req_o,
    output mem_stage_pkg::mem_req_t               dmem_req_fields_o,
    input  logic                                  dmem_gnt_i,
    input  logic                                  dmem_rvalid_i,
    // Status to controller
    output logic                                  dmem_stall_o,
    output logic                                  unalign_load_ex_o,
    output logic                                  unalign_store_ex_o,
    // To writeback
    output logic                                  valid_o,
    output mem_stage_pkg::wb_payload_t            wb_o,
    output mem_stage_pkg::load_fmt_t              load_fmt_o
);

    import mem_stage_pkg::*;

    logic        valid_trk; // Valid after squash and bubble
    mem_req_t    dec_req;   // Decoded address phase
    logic        rd_req;    // Aligned load request
    logic        wr_req;    // Aligned store request
    logic        illegal;   // Misaligned or bad width
    wb_payload_t wb_in;     // Packed destination info
    load_fmt_t   fmt_in;    // Packed load format

    assign wb_in = '{pc: pc_i, rd_data: rd_data_i, rd_idx: rd_idx_i,
                     rd_wr_en: rd_wr_en_i, rd_wr_src_load: rd_wr_src_load_i};
    assign fmt_in = '{width_1h: ctrl_i.width_1h, sign: ctrl_i.sign,
                      byte_addr: addr_i[BYTE_OFS_W-1:0]};

    ////////////////////////////////////////////////////////////
    // Validity and decoding
    ////////////////////////////////////////////////////////////

    validity_tracker u_validity_tracker (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .valid_i  (valid_i),
        .squash_i (squash_i),
        .bubble_i (bubble_i),
        .stall_i  (stall_i),
        .valid_o  (valid_trk)
    );

    access_decoder u_access_decoder (
        .valid_i            (valid_i), // Raw valid avoids a loop through the tracker
        .addr_i             (addr_i),
        .rs2_data_i         (rs2_data_i),
        .ctrl_i             (ctrl_i),
        .req_o              (dec_req),
        .rd_req_o           (rd_req),
        .wr_req_o           (wr_req),
        .illegal_o          (illegal),
        .unalign_load_ex_o  (unalign_load_ex_o),
        .unalign_store_ex_o (unalign_store_ex_o)
    );

    ////////////////////////////////////////////////////////////
    // Data port and output registers
    ////////////////////////////////////////////////////////////

    obi_host_driver u_obi_host_driver (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rd_i         (rd_req),
        .wr_i         (wr_req),
        .req_i        (dec_req),
        .gnt_i        (dmem_gnt_i),
        .rvalid_i     (dmem_rvalid_i),
        .stall_i      (stall_i),
        .req_o        (dmem_req_o),
        .req_fields_o (dmem_req_fields_o),
        .stall_o      (dmem_stall_o)
    );

    mem_stage_regs u_mem_stage_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .stall_i    (stall_i),
        .valid_i    (valid_trk),
        .illegal_i  (illegal),
        .rd_i       (ctrl_i.rd),
        .wr_i       (ctrl_i.wr),
        .wb_i       (wb_in),
        .load_fmt_i (fmt_in),
        .valid_o    (valid_o),
        .wb_o       (wb_o),
        .load_fmt_o (load_fmt_o)
    );

endmodule

/* tb/tb_mem_stage.sv */
// Memory stage testbench
// Directed and random load/store traffic against an OBI memory responder
`timescale 1ns/100ps

module tb_mem_stage;

    import mem_stage_pkg::*;

    localparam int TIMEOUT = 100; // Cycles per wait loop

    logic clk_i = 1'b0;
    logic rst_ni, squash_i, bubble_i, stall_i, valid_i, rd_wr_en_i, rd_wr_src_load_i;
    logic [VADDR-1:0] pc_i, addr_i;
    logic [XLEN-1:0] rs2_data_i, rd_data_i;
    logic [REG_IDX_W-1:0] rd_idx_i;
    mem_ctrl_t ctrl_i;
    logic dmem_gnt_i, dmem_rvalid_i, dmem_req_o, dmem_stall_o;
    logic unalign_load_ex_o, unalign_store_ex_o, valid_o;
    mem_req_t dmem_req_fields_o;
    wb_payload_t wb_o;
    load_fmt_t load_fmt_o;

    logic extra_stall;     // Stall from the rest of the pipeline
    int gnt_delay, rsp_delay, wait_cnt, rsp_cnt, hs_count, value_errors, other_errors;
    logic rsp_busy;        // Responder owes an rvalid

    assign stall_i = dmem_stall_o | extra_stall; // Controller holds the stage

    always #10 clk_i = ~clk_i; // 20 ns period

    mem_stage UUT (.*);

    ////////////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            dmem_gnt_i <= 1'b0;
            dmem_rvalid_i <= 1'b0;
            wait_cnt <= 0;
            rsp_cnt <= 0;
            rsp_busy <= 1'b0;
        end else begin
            dmem_rvalid_i <= 1'b0;
            if (dmem_gnt_i && dmem_req_o) begin // Handshake on this edge
                hs_count++;
                dmem_gnt_i <= 1'b0;
                rsp_cnt <= 1;
                if (rsp_delay <= 1) dmem_rvalid_i <= 1'b1;
                else rsp_busy <= 1'b1;
            end else if (rsp_busy) begin
                rsp_cnt <= rsp_cnt + 1;
                if (rsp_cnt + 1 >= rsp_delay) begin
                    dmem_rvalid_i <= 1'b1;
                    rsp_busy <= 1'b0;
                end
            end else if (dmem_req_o && !dmem_gnt_i) begin
                if (wait_cnt >= gnt_delay) begin
                    dmem_gnt_i <= 1'b1; // Grant after programmed delay
                    wait_cnt <= 0;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end else begin
                dmem_gnt_i <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Expected values and compares
    ////////////////////////////////////////////////////////////

    function automatic int access_size(input logic [WIDTH_1H_W-1:0] w);
        case (w)
            MEM_WIDTH_BYTE:   return 1;
            MEM_WIDTH_HALF:   return 2;
            MEM_WIDTH_WORD:   return 4;
            MEM_WIDTH_DOUBLE: return 8;
            default:          return 0; // Not a width
        endcase
    endfunction

    function automatic logic access_legal(input logic [WIDTH_1H_W-1:0] w, input int ofs);
        int size;
        size = access_size(w);
        return size != 0 && (ofs % size) == 0; // Natural alignment
    endfunction

    function automatic mem_req_t expected_req(input mem_ctrl_t c, input logic [VADDR-1:0] a,
                                              input logic [XLEN-1:0] d);
        mem_req_t r;
        int size;
        int ofs;
        logic legal;
        size = access_size(c.width_1h);
        ofs = int'(a[2:0]);
        legal = access_legal(c.width_1h, ofs);
        r.addr = {a[VADDR-1:3], 3'b000};
        r.we = c.wr & legal;
        for (int i = 0; i < BE_W; i++) begin
            r.be[i] = legal && i >= ofs && i < ofs + size; // Lanes covered by the access
            r.wdata[8*i +: 8] = (size == 0) ? d[8*i +: 8] : d[8*(i % size) +: 8];
        end
        return r;
    endfunction

    task automatic compare_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_wb(input string name, input wb_payload_t got, input wb_payload_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_fmt(input string name, input load_fmt_t got, input load_fmt_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Access driver
    ////////////////////////////////////////////////////////////

    // kill_mode 0 none, 1 squash level, 2 bubble level, 3 squash pulse, 4 bubble pulse
    task automatic do_access(input mem_ctrl_t ctrl, input logic [VADDR-1:0] addr,
                             input logic [XLEN-1:0] data, input int gnt_dly, input int rsp_dly,
                             input int kill_mode, input int hold_after);
        mem_req_t exp_r;
        wb_payload_t exp_wb;
        load_fmt_t exp_fmt;
        logic [63:0] rnd;
        logic legal;
        logic rsp_seen;
        logic done;
        int cyc;
        int hold_cnt;
        int hs_start;
        legal = access_legal(ctrl.width_1h, int'(addr[2:0]));
        exp_r = expected_req(ctrl, addr, data);
        rnd = {$urandom(), $urandom()};
        exp_wb.pc = rnd[VADDR-1:0];
        exp_wb.rd_data = {$urandom(), $urandom()};
        rnd = {$urandom(), $urandom()};
        exp_wb.rd_idx = rnd[REG_IDX_W-1:0];
        exp_wb.rd_wr_src_load = ctrl.rd;
        exp_wb.rd_wr_en = ctrl.rd && kill_mode == 0; // Killed instructions write nothing
        exp_fmt = '{width_1h: ctrl.width_1h, sign: ctrl.sign, byte_addr: addr[2:0]};
        gnt_delay = gnt_dly;
        rsp_delay = rsp_dly;
        hs_start = hs_count;
        @(posedge clk_i);
        valid_i <= 1'b1;
        ctrl_i <= ctrl;
        addr_i <= addr;
        rs2_data_i <= data;
        pc_i <= exp_wb.pc;
        rd_data_i <= exp_wb.rd_data;
        rd_idx_i <= exp_wb.rd_idx;
        rd_wr_en_i <= ctrl.rd;
        rd_wr_src_load_i <= ctrl.rd;
        squash_i <= kill_mode == 1;
        bubble_i <= kill_mode == 2;
        extra_stall <= hold_after > 0;
        @(negedge clk_i);
        compare_bit("unalign_load_ex_o", unalign_load_ex_o, !legal && ctrl.rd);
        compare_bit("unalign_store_ex_o", unalign_store_ex_o, !legal && ctrl.wr);
        compare_bit("dmem_req_o", dmem_req_o, legal);
        cyc = 0;
        hold_cnt = 0;
        rsp_seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            if (dmem_req_o) compare_req("dmem_req_fields_o", dmem_req_fields_o, exp_r);
            if (dmem_rvalid_i) begin
                rsp_seen = 1'b1;
                compare_bit("dmem_stall_o", dmem_stall_o, 1'b0); // Falls with rvalid
            end else if (legal && !rsp_seen) begin
                compare_bit("dmem_stall_o", dmem_stall_o, 1'b1);
            end
            if (!stall_i) begin
                done = 1'b1;
            end else if (cyc >= TIMEOUT) begin
                other_errors++;
                $display("Timeout: the stage stayed stalled on a memory access");
                done = 1'b1;
            end else begin
                @(posedge clk_i);
                cyc++;
                if (kill_mode == 3) squash_i <= cyc == 1; // Kill seen only in the stall
                if (kill_mode == 4) bubble_i <= cyc == 1;
                if (rsp_seen) begin
                    hold_cnt++;
                    if (hold_cnt >= hold_after) extra_stall <= 1'b0;
                end
                @(negedge clk_i);
            end
        end
        @(posedge clk_i); // Release edge, stage captures
        valid_i <= 1'b0;
        ctrl_i <= '0;
        squash_i <= 1'b0;
        bubble_i <= 1'b0;
        extra_stall <= 1'b0;
        @(negedge clk_i);
        compare_bit("valid_o", valid_o, legal && kill_mode == 0);
        compare_wb("wb_o", wb_o, exp_wb);
        compare_fmt("load_fmt_o", load_fmt_o, exp_fmt);
        if (hs_count - hs_start != (legal ? 1 : 0)) begin
            other_errors++;
            $display("Wrong number of bus transactions: %0d", hs_count - hs_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        @(negedge clk_i);
        compare_bit("valid_o", valid_o, 1'b0);
        compare_bit("dmem_req_o", dmem_req_o, 1'b0);
        compare_bit("dmem_stall_o", dmem_stall_o, 1'b0);
        compare_wb("wb_o", wb_o, '0);
        compare_fmt("load_fmt_o", load_fmt_o, '0);
    endtask

    task automatic test_store_widths();
        mem_ctrl_t c;
        for (int w = 0; w < 4; w++) begin
            c = '{width_1h: 4'(1 << w), rd: 1'b0, wr: 1'b1, sign: 1'b0};
            for (int ofs = 0; ofs < 8; ofs += (1 << w)) begin
                do_access(c, {36'h123456789, 3'(ofs)}, 64'h8877_6655_4433_2211, 0, 1, 0, 0);
            end
        end
    endtask

    task automatic test_misaligned();
        mem_ctrl_t c;
        for (int k = 0; k < 2; k++) begin // Loads then stores
            c = '{width_1h: MEM_WIDTH_HALF, rd: k == 0, wr: k == 1, sign: 1'b1};
            do_access(c, 39'h40_0000_0011, 64'hcafe, 0, 1, 0, 0);
            c.width_1h = MEM_WIDTH_WORD;
            do_access(c, 39'h40_0000_0012, 64'hdead_beef, 0, 1, 0, 0);
            c.width_1h = MEM_WIDTH_DOUBLE;
            do_access(c, 39'h40_0000_0014, 64'h0123_4567_89ab_cdef, 0, 1, 0, 0);
        end
        c = '{width_1h: 4'b0011, rd: 1'b1, wr: 1'b0, sign: 1'b0}; // Bad width code
        do_access(c, 39'h40_0000_0000, 64'h55, 0, 1, 0, 0);
    endtask

    task automatic test_backpressure();
        mem_ctrl_t c;
        c = '{width_1h: MEM_WIDTH_WORD, rd: 1'b1, wr: 1'b0, sign: 1'b1};
        do_access(c, 39'h12_3456_7804, 64'h0, 3, 2, 0, 0);
    endtask

    task automatic test_kill();
        mem_ctrl_t c;
        c = '{width_1h: MEM_WIDTH_DOUBLE, rd: 1'b1, wr: 1'b0, sign: 1'b0};
        for (int mode = 1; mode <= 4; mode++) begin
            do_access(c, 39'h00_1000_0040, 64'h0, 3, 2, mode, 0);
        end
        do_access(c, 39'h00_1000_0048, 64'h0, 1, 2, 0, 3); // Parked under extra stall
    endtask

    task automatic test_random();
        mem_ctrl_t c;
        logic [63:0] rnd;
        int size;
        for (int n = 0; n < 50; n++) begin
            c.width_1h = 4'(1 << ($urandom() % 4));
            c.rd = $urandom() % 2 == 0;
            c.wr = !c.rd;
            c.sign = $urandom() % 2 == 1;
            size = access_size(c.width_1h);
            rnd = {$urandom(), $urandom()};
            rnd[2:0] = 3'((($urandom() % 8) / size) * size); // Aligned offset
            do_access(c, rnd[VADDR-1:0], {$urandom(), $urandom()},
                      int'($urandom() % 4), 1 + int'($urandom() % 3), 0, 0);
        end
    endtask

    initial begin
        void'($urandom(32'h2bc4c0fb));
        {squash_i, bubble_i, valid_i, rd_wr_en_i, rd_wr_src_load_i, extra_stall} <= '0;
        {pc_i, addr_i, rs2_data_i, rd_data_i, rd_idx_i, ctrl_i} <= '0;
        {dmem_gnt_i, dmem_rvalid_i} <= '0; // Responder idle until reset
        {hs_count, value_errors, other_errors} = '0;
        gnt_delay = 0;
        rsp_delay = 1;
        rst_ni <= 1'b0;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        test_reset();
        test_store_widths();
        test_misaligned();
        test_backpressure();
        test_kill();
        test_random();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* mem_stage.f */
common/mem_stage_pkg.sv
source/validity_tracker.sv
mem_stage/access_decoder.sv
obi/obi_host_driver.sv
mem_stage/mem_stage_regs.sv
mem_stage/mem_stage.sv
tb/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_stage.f --top-module tb_mem_stage -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_mem_stage)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
